/* run_sim.sh */
#!/bin/sh
# Compile and run the traffic node testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module traffic_node_tb \
    -o Vtraffic_node_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtraffic_node_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

/* source/flit_pkg.sv */
package flit_pkg;

    `include "noc_settings.svh"

    // top two flit bits
    typedef enum logic [1:0] {
        BODY   = 2'b00,
        TAIL   = 2'b01,
        HEADER = 2'b10
    } flit_kind_e;

    typedef logic [`NOC_V-1:0] vc_mask_t; // one-hot
    typedef logic [$clog2(`NOC_V)-1:0] vc_index_t;
    typedef logic [3:0] coord_field_t;

    typedef struct packed {
        flit_kind_e kind;
        vc_mask_t vc; // right below the kind bits
        logic [`NOC_FPAY-1:0] payload;
    } flit_t;

    // header payload, coordinates in the low 16 bits
    typedef struct packed {
        logic [`NOC_FPAY-17:0] pad;
        coord_field_t dest_x;
        coord_field_t dest_y;
        coord_field_t src_x;
        coord_field_t src_y;
    } hdr_payload_t;

    typedef struct packed {
        logic [`NOC_FPAY-`NOC_PCK_CNT_W-`NOC_PCK_SIZ_W-1:0] pad;
        logic [`NOC_PCK_CNT_W-1:0] pck_number;
        logic [`NOC_PCK_SIZ_W-1:0] flit_idx; // 1 for the first body flit
    } body_payload_t;

    typedef struct packed {
        logic [`NOC_FPAY-`NOC_CLK_CNT_W-1:0] pad;
        logic [`NOC_CLK_CNT_W-1:0] timestamp; // injection time
    } tail_payload_t;

    function automatic vc_index_t vc_index(vc_mask_t mask);
        vc_index_t idx;
        idx = '0;
        for (int i = 0; i < `NOC_V; i++) begin
            if (mask[i]) idx = vc_index_t'(i);
        end
        return idx;
    endfunction

endpackage

/* source/flit_sender.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module flit_sender (
    input  logic clk,
    input  logic reset,
    input  logic [`NOC_PCK_SIZ_W-1:0] pck_size,
    input  node_pkg::x_coord_t current_x,
    input  node_pkg::y_coord_t current_y,
    input  node_pkg::x_coord_t dest_x,
    input  node_pkg::y_coord_t dest_y,
    input  logic queue_empty,
    input  node_pkg::timestamp_t head_timestamp,
    input  flit_pkg::vc_mask_t full_vc,
    input  flit_pkg::vc_mask_t cand_vc,
    output logic pop,
    output logic cand_en,
    output flit_pkg::vc_mask_t wr_vc,
    output flit_pkg::flit_t flit_out,
    output logic flit_out_wr,
    output logic sent_done,
    output logic [`NOC_PCK_CNT_W-1:0] pck_number
);

    node_pkg::send_state_e state, state_next;
    flit_pkg::vc_mask_t wr_vc_next;
    logic [`NOC_PCK_SIZ_W-1:0] flit_cnt, flit_cnt_next;
    node_pkg::timestamp_t tail_ts; // held from the header pop
    logic valid_dst;
    logic wr_vc_full;
    flit_pkg::hdr_payload_t hdr;
    flit_pkg::body_payload_t body;
    flit_pkg::tail_payload_t tail;

    assign valid_dst = ({dest_x, dest_y} != {current_x, current_y})
                    && (int'(dest_x) < `NOC_NX) && (int'(dest_y) < `NOC_NY);
    assign wr_vc_full = |(full_vc & wr_vc);

    always_comb begin
        state_next = state;
        wr_vc_next = wr_vc;
        flit_cnt_next = flit_cnt;
        pop = 1'b0;
        cand_en = 1'b0;
        flit_out_wr = 1'b0;
        sent_done = 1'b0;
        case (state)
            node_pkg::IDLE: begin
                if (!queue_empty && valid_dst && !wr_vc_full) begin
                    pop = 1'b1; // header goes out now
                    flit_out_wr = 1'b1;
                    flit_cnt_next = `NOC_PCK_SIZ_W'(1);
                    state_next = node_pkg::SEND;
                end
            end
            node_pkg::SEND: begin
                if (!wr_vc_full) begin
                    flit_out_wr = 1'b1;
                    if (flit_cnt < pck_size - 1'b1) begin
                        flit_cnt_next = flit_cnt + 1'b1;
                    end else begin
                        flit_cnt_next = '0;
                        sent_done = 1'b1;
                        cand_en = 1'b1;
                        if (cand_vc != '0) begin
                            wr_vc_next = cand_vc;
                            state_next = node_pkg::IDLE;
                        end else begin
                            state_next = node_pkg::WAIT;
                        end
                    end
                end
            end
            node_pkg::WAIT: begin
                cand_en = 1'b1;
                if (cand_vc != '0) begin
                    wr_vc_next = cand_vc;
                    state_next = node_pkg::IDLE;
                end
            end
            default: state_next = node_pkg::IDLE;
        endcase
    end

    // payload variants
    always_comb begin
        hdr = '0;
        hdr.dest_x = flit_pkg::coord_field_t'(dest_x);
        hdr.dest_y = flit_pkg::coord_field_t'(dest_y);
        hdr.src_x = flit_pkg::coord_field_t'(current_x);
        hdr.src_y = flit_pkg::coord_field_t'(current_y);
        body = '0;
        body.pck_number = pck_number;
        body.flit_idx = flit_cnt;
        tail = '0;
        tail.timestamp = tail_ts;
    end

    always_comb begin
        flit_out.vc = wr_vc;
        if (flit_cnt == '0) begin
            flit_out.kind = flit_pkg::HEADER;
            flit_out.payload = hdr;
        end else if (flit_cnt >= pck_size - 1'b1) begin
            flit_out.kind = flit_pkg::TAIL;
            flit_out.payload = tail;
        end else begin
            flit_out.kind = flit_pkg::BODY;
            flit_out.payload = body;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= node_pkg::IDLE;
            wr_vc <= flit_pkg::vc_mask_t'(1); // VC0
            flit_cnt <= '0;
            pck_number <= '0;
        end else begin
            state <= state_next;
            wr_vc <= wr_vc_next;
            flit_cnt <= flit_cnt_next;
            if (pop) pck_number <= pck_number + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) tail_ts <= head_timestamp;
    end

    // exactly one written VC and it has room
    a_no_wr_when_full: assert property (@(posedge clk) disable iff (reset)
        flit_out_wr |-> $onehot(flit_out.vc) && !(|(full_vc & flit_out.vc)));

endmodule

/* source/flit_sink.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module flit_sink (
    input  logic clk,
    input  logic reset,
    input  flit_pkg::flit_t flit_in,
    input  logic flit_in_wr,
    input  node_pkg::timestamp_t now_time,
    input  node_pkg::x_coord_t current_x,
    input  node_pkg::y_coord_t current_y,
    output flit_pkg::vc_mask_t credit_out,
    output logic pck_received,
    output node_pkg::timestamp_t latency,
    output node_pkg::hop_count_t distance
);

    flit_pkg::vc_index_t in_idx;
    flit_pkg::hdr_payload_t hdr_in;
    flit_pkg::tail_payload_t tail_in;
    flit_pkg::coord_field_t src_x_q [`NOC_V]; // per VC, from the header
    flit_pkg::coord_field_t src_y_q [`NOC_V];
    node_pkg::x_coord_t src_x, dx;
    node_pkg::y_coord_t src_y, dy;

    assign in_idx = flit_pkg::vc_index(flit_in.vc);
    assign hdr_in = flit_in.payload;
    assign tail_in = flit_in.payload;

    assign src_x = node_pkg::x_coord_t'(src_x_q[in_idx]);
    assign src_y = node_pkg::y_coord_t'(src_y_q[in_idx]);
    assign dx = (src_x > current_x) ? src_x - current_x : current_x - src_x;
    assign dy = (src_y > current_y) ? src_y - current_y : current_y - src_y;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_out <= '0;
            pck_received <= 1'b0;
        end else begin
            credit_out <= flit_in_wr ? flit_in.vc : '0; // one credit per flit
            pck_received <= flit_in_wr && (flit_in.kind == flit_pkg::TAIL);
        end
    end

    always_ff @(posedge clk) begin
        if (flit_in_wr && flit_in.kind == flit_pkg::HEADER) begin
            src_x_q[in_idx] <= hdr_in.src_x;
            src_y_q[in_idx] <= hdr_in.src_y;
        end
        if (flit_in_wr && flit_in.kind == flit_pkg::TAIL) begin
            latency <= now_time - tail_in.timestamp; // mod 2^16
            distance <= node_pkg::hop_count_t'(dx) + node_pkg::hop_count_t'(dy) + 1'b1;
        end
    end

    // network delivered the packet to the right node
    a_hdr_dest: assert property (@(posedge clk) disable iff (reset)
        (flit_in_wr && flit_in.kind == flit_pkg::HEADER) |->
        (hdr_in.dest_x == flit_pkg::coord_field_t'(current_x)
         && hdr_in.dest_y == flit_pkg::coord_field_t'(current_y)));

endmodule

/* source/injection_ratio_ctrl.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module injection_ratio_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [`NOC_RATIO_W-1:0] ratio,
    input  logic [`NOC_PCK_SIZ_W-1:0] pck_size,
    input  logic queue_full,
    output logic inject
);

    localparam int ACC_INIT = `NOC_MAX_PCK_SIZ * 100;
    localparam int ACC_W = $clog2(`NOC_MAX_PCK_SIZ * 200);
    localparam logic [`NOC_RATIO_W-1:0] FULL_RATIO = 100;

    logic enabled;
    logic [`NOC_RATIO_W-1:0] ratio_q;
    logic ratio_changed;
    logic [ACC_W-1:0] acc, acc_next;
    logic sending, sending_next; // flit slot phase vs idle phase
    logic [`NOC_PCK_SIZ_W-1:0] slot_cnt, slot_cnt_next;

    assign ratio_changed = (ratio_q != ratio);

    always_comb begin
        acc_next = acc;
        sending_next = sending;
        slot_cnt_next = slot_cnt;
        inject = 1'b0;
        if (ratio_changed) begin
            acc_next = ACC_W'(ACC_INIT); // restart pacing
            sending_next = 1'b1;
            slot_cnt_next = '0;
        end else if (enabled && !queue_full) begin
            if (sending) begin
                acc_next = acc + ACC_W'(FULL_RATIO - ratio);
                inject = (slot_cnt == '0) && (ratio != '0);
                if (slot_cnt == pck_size - 1'b1) begin
                    slot_cnt_next = '0;
                    // packet done, pay back the on-time
                    if (acc_next >= ACC_W'(ACC_INIT)) sending_next = 1'b0;
                end else begin
                    slot_cnt_next = slot_cnt + 1'b1;
                end
            end else begin
                acc_next = acc - ACC_W'(ratio);
                if (acc_next < ACC_W'(ACC_INIT)) sending_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enabled <= 1'b0;
            ratio_q <= '0;
            acc <= ACC_W'(ACC_INIT);
            sending <= 1'b1;
            slot_cnt <= '0;
        end else begin
            enabled <= enabled | start; // sticky
            ratio_q <= ratio;
            acc <= acc_next;
            sending <= sending_next;
            slot_cnt <= slot_cnt_next;
        end
    end

endmodule

/* source/noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// mesh size
`define NOC_NX 4
`define NOC_NY 4

// virtual channels and downstream buffering
`define NOC_V 2
`define NOC_B 4 // flit slots per VC in the next router

// flit geometry
`define NOC_FPAY 32
`define NOC_FLIT_W (2 + `NOC_V + `NOC_FPAY)

// packet sizing and counters
`define NOC_MAX_PCK_SIZ 10
`define NOC_PCK_SIZ_W 4
`define NOC_RATIO_W 7 // 0..100 percent
`define NOC_CLK_CNT_W 16
`define NOC_PCK_CNT_W 14

// injection timestamp queue
`define NOC_TS_FIFO_DEPTH 16

`endif

/* source/node_pkg.sv */
package node_pkg;

    `include "noc_settings.svh"

    // injection side FSM
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT // no free VC after the last tail
    } send_state_e;

    typedef logic [$clog2(`NOC_NX)-1:0] x_coord_t;
    typedef logic [$clog2(`NOC_NY)-1:0] y_coord_t;

    typedef logic [`NOC_CLK_CNT_W-1:0] timestamp_t;

    // hop count incl. the final router
    typedef logic [3:0] hop_count_t;

endpackage

/* source/ovc_credit_tracker.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module ovc_credit_tracker (
    input  logic clk,
    input  logic reset,
    input  logic flit_out_wr,
    input  flit_pkg::vc_mask_t wr_vc,
    input  flit_pkg::vc_mask_t credit_in,
    input  logic cand_en,
    output flit_pkg::vc_mask_t full_vc,
    output flit_pkg::vc_mask_t cand_vc
);

    localparam int CNT_W = $clog2(`NOC_B + 1);

    logic [CNT_W-1:0] credit_cnt [`NOC_V];
    flit_pkg::vc_mask_t wr_dec;
    flit_pkg::vc_mask_t cand_sel;

    assign wr_dec = flit_out_wr ? wr_vc : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NOC_V; i++) credit_cnt[i] <= CNT_W'(`NOC_B);
        end else begin
            for (int i = 0; i < `NOC_V; i++) begin
                // write and credit in one cycle cancel out
                if (credit_in[i] && !wr_dec[i]) begin
                    credit_cnt[i] <= credit_cnt[i] + 1'b1;
                end else if (!credit_in[i] && wr_dec[i]) begin
                    credit_cnt[i] <= credit_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NOC_V; i++) full_vc[i] = (credit_cnt[i] == '0);
    end

    // round robin, first non-full VC after the current one
    always_comb begin
        int pos;
        cand_sel = '0;
        for (int off = `NOC_V; off >= 1; off--) begin
            pos = (int'(flit_pkg::vc_index(wr_vc)) + off) % `NOC_V;
            if (!full_vc[pos]) begin
                cand_sel = '0;
                cand_sel[pos] = 1'b1; // smaller offset overrides
            end
        end
    end

    assign cand_vc = cand_en ? cand_sel : '0; // only offered on request

    // downstream router never returns more credits than it has slots
    for (genvar g = 0; g < `NOC_V; g++) begin : g_bound
        a_credit_bound: assert property (@(posedge clk) disable iff (reset)
            credit_cnt[g] <= CNT_W'(`NOC_B));
    end

endmodule

/* source/timestamp_queue.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module timestamp_queue (
    input  logic clk,
    input  logic reset,
    input  logic inject,
    input  logic pop,
    output logic queue_full,
    output logic queue_empty,
    output node_pkg::timestamp_t head_timestamp,
    output node_pkg::timestamp_t now_time
);

    localparam int DEPTH = `NOC_TS_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);

    node_pkg::timestamp_t mem [DEPTH];
    logic [AW:0] wr_ptr, rd_ptr; // extra wrap bit
    logic do_wr, do_rd;

    assign queue_empty = (wr_ptr == rd_ptr);
    assign queue_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign head_timestamp = mem[rd_ptr[AW-1:0]];

    assign do_wr = inject && !queue_full;
    assign do_rd = pop && !queue_empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            now_time <= '0; // 0 in the first cycle out of reset
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            now_time <= now_time + 1'b1; // wraps at 16 bits
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr[AW-1:0]] <= now_time;
    end

    // pacing must freeze on full, sender must wait for an entry
    a_queue_flow: assert property (@(posedge clk) disable iff (reset)
        !(inject && queue_full) && !(pop && queue_empty));

endmodule

/* source/traffic_node.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module traffic_node (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [`NOC_RATIO_W-1:0] ratio,
    input  logic [`NOC_PCK_SIZ_W-1:0] pck_size,
    input  node_pkg::x_coord_t current_x,
    input  node_pkg::y_coord_t current_y,
    input  node_pkg::x_coord_t dest_x,
    input  node_pkg::y_coord_t dest_y,
    // injection side
    output flit_pkg::flit_t flit_out,
    output logic flit_out_wr,
    input  flit_pkg::vc_mask_t credit_in,
    output logic sent_done,
    output logic [`NOC_PCK_CNT_W-1:0] pck_number,
    // ejection side
    input  flit_pkg::flit_t flit_in,
    input  logic flit_in_wr,
    output flit_pkg::vc_mask_t credit_out,
    output logic pck_received,
    output node_pkg::timestamp_t latency,
    output node_pkg::hop_count_t distance
);

    logic inject, pop, queue_full, queue_empty, cand_en;
    node_pkg::timestamp_t head_timestamp, now_time;
    flit_pkg::vc_mask_t wr_vc, full_vc, cand_vc;

    injection_ratio_ctrl ratio_ctrl_inst (
        .clk(clk), .reset(reset), .start(start), .ratio(ratio),
        .pck_size(pck_size), .queue_full(queue_full), .inject(inject)
    );

    timestamp_queue ts_queue_inst (
        .clk(clk), .reset(reset), .inject(inject), .pop(pop),
        .queue_full(queue_full), .queue_empty(queue_empty),
        .head_timestamp(head_timestamp), .now_time(now_time)
    );

    ovc_credit_tracker credit_tracker_inst (
        .clk(clk), .reset(reset), .flit_out_wr(flit_out_wr), .wr_vc(wr_vc),
        .credit_in(credit_in), .cand_en(cand_en), .full_vc(full_vc), .cand_vc(cand_vc)
    );

    flit_sender sender_inst (
        .clk(clk), .reset(reset), .pck_size(pck_size),
        .current_x(current_x), .current_y(current_y), .dest_x(dest_x), .dest_y(dest_y),
        .queue_empty(queue_empty), .head_timestamp(head_timestamp),
        .full_vc(full_vc), .cand_vc(cand_vc), .pop(pop), .cand_en(cand_en),
        .wr_vc(wr_vc), .flit_out(flit_out), .flit_out_wr(flit_out_wr),
        .sent_done(sent_done), .pck_number(pck_number)
    );

    flit_sink sink_inst (
        .clk(clk), .reset(reset), .flit_in(flit_in), .flit_in_wr(flit_in_wr),
        .now_time(now_time), .current_x(current_x), .current_y(current_y),
        .credit_out(credit_out), .pck_received(pck_received),
        .latency(latency), .distance(distance)
    );

endmodule

/* src.f */
+incdir+source
source/flit_pkg.sv
source/node_pkg.sv
source/injection_ratio_ctrl.sv
source/timestamp_queue.sv
source/ovc_credit_tracker.sv
source/flit_sender.sv
source/flit_sink.sv
source/traffic_node.sv
verification/traffic_node_tb.sv

/* verification/traffic_node_tb.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module traffic_node_tb;

    logic clk, reset, start;
    logic [`NOC_RATIO_W-1:0] ratio;
    logic [`NOC_PCK_SIZ_W-1:0] pck_size;
    node_pkg::x_coord_t current_x, dest_x;
    node_pkg::y_coord_t current_y, dest_y;
    flit_pkg::flit_t flit_out, flit_in;
    logic flit_out_wr, flit_in_wr, sent_done, pck_received;
    flit_pkg::vc_mask_t credit_in, credit_out;
    logic [`NOC_PCK_CNT_W-1:0] pck_number;
    node_pkg::timestamp_t latency;
    node_pkg::hop_count_t distance;

    int cyc; // model time base, 0 in the first cycle after reset
    int sent_cnt [`NOC_V];
    int ret_cnt [`NOC_V];
    bit hold_credits;
    int pck_model;
    int errors, passed, failed, checks;
    logic [`NOC_V-1:0] exp_credit;
    logic exp_rcv;
    logic [15:0] exp_lat;
    logic [3:0] exp_dist;
    int sink_sx, sink_sy;

    traffic_node traffic_node_inst (
        .clk(clk), .reset(reset), .start(start), .ratio(ratio), .pck_size(pck_size),
        .current_x(current_x), .current_y(current_y), .dest_x(dest_x), .dest_y(dest_y),
        .flit_out(flit_out), .flit_out_wr(flit_out_wr), .credit_in(credit_in),
        .sent_done(sent_done), .pck_number(pck_number), .flit_in(flit_in),
        .flit_in_wr(flit_in_wr), .credit_out(credit_out), .pck_received(pck_received),
        .latency(latency), .distance(distance)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (reset) cyc <= 0;
        else cyc <= cyc + 1;
    end

    task automatic check_eq(input string name, input logic [35:0] got, input logic [35:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    // outstanding flits per VC, seen from the downstream router
    always @(negedge clk) begin
        if (!reset && flit_out_wr) begin
            for (int v = 0; v < `NOC_V; v++) begin
                if (flit_out.vc[v]) sent_cnt[v]++;
            end
            for (int v = 0; v < `NOC_V; v++) begin
                checks++;
                assert (sent_cnt[v] - ret_cnt[v] <= `NOC_B) else begin
                    $display("VC %0d has %0d flits outstanding, more than the buffer holds",
                             v, sent_cnt[v] - ret_cnt[v]);
                    errors++;
                end
            end
        end
    end

    // downstream credit return, throttled in back-pressure mode
    always @(posedge clk) begin
        flit_pkg::vc_mask_t bits;
        bits = '0;
        if (!reset) begin
            for (int v = 0; v < `NOC_V; v++) begin
                if (ret_cnt[v] < sent_cnt[v] && (!hold_credits || $urandom_range(3) == 0)) begin
                    bits[v] = 1'b1;
                    ret_cnt[v]++;
                end
            end
        end
        credit_in <= bits;
    end

    // ratio held just long enough for one inject pulse
    task automatic inject_packet(output int ts);
        @(posedge clk) ratio <= 50;
        @(posedge clk);
        @(negedge clk) ts = cyc;
        @(posedge clk) ratio <= 0;
    endtask

    task automatic collect_packet(input int size, input int ts);
        flit_pkg::flit_t f;
        flit_pkg::vc_mask_t pvc;
        int waitc;
        pvc = '0;
        for (int i = 0; i < size; i++) begin
            waitc = 0;
            do begin
                @(negedge clk);
                waitc++;
            end while (!flit_out_wr && waitc < 600);
            if (!flit_out_wr) begin
                $display("timeout: flit %0d of a %0d flit packet never appeared", i, size);
                errors++;
                return;
            end
            f = flit_out;
            if (i == 0) begin
                pvc = f.vc;
                pck_model++;
                check_eq("flit_out.vc onehot", $onehot(f.vc), 1);
                check_eq("flit_out.kind", f.kind, flit_pkg::HEADER);
                check_eq("flit_out.payload", f.payload, {16'h0, 4'(dest_x), 4'(dest_y),
                         4'(current_x), 4'(current_y)});
            end else begin
                check_eq("flit_out.vc", f.vc, pvc);
            end
            if (i == size - 1) begin
                check_eq("flit_out.kind", f.kind, flit_pkg::TAIL);
                check_eq("flit_out.payload", f.payload, {16'h0, 16'(ts)});
                check_eq("sent_done", sent_done, 1);
            end else begin
                check_eq("sent_done", sent_done, 0);
                if (i > 0) begin
                    check_eq("flit_out.kind", f.kind, flit_pkg::BODY);
                    check_eq("flit_out.payload", f.payload, {14'h0, 14'(pck_model), 4'(i)});
                end
            end
        end
        @(negedge clk);
        check_eq("pck_number", pck_number, 36'(14'(pck_model)));
    endtask

    task automatic drain_sender();
        int quiet;
        int waitc;
        quiet = 0;
        waitc = 0;
        while (quiet < 20 && waitc < 3000) begin
            @(negedge clk);
            waitc++;
            quiet = flit_out_wr ? 0 : quiet + 1;
        end
        if (quiet < 20) begin
            $display("timeout: sender never went quiet");
            errors++;
        end
    endtask

    // random destination other than the node, driven on the next rising edge
    task automatic pick_dest();
        node_pkg::x_coord_t x;
        node_pkg::y_coord_t y;
        do begin
            x = node_pkg::x_coord_t'($urandom_range(`NOC_NX - 1));
            y = node_pkg::y_coord_t'($urandom_range(`NOC_NY - 1));
        end while (x == current_x && y == current_y);
        @(posedge clk);
        dest_x <= x;
        dest_y <= y;
    endtask

    // checks the previous flit's response, then drives the next one
    task automatic sink_step(input bit w, input flit_pkg::flit_t f);
        @(posedge clk);
        flit_in_wr <= w;
        flit_in <= f;
        @(negedge clk);
        check_eq("credit_out", credit_out, exp_credit);
        check_eq("pck_received", pck_received, exp_rcv);
        if (exp_rcv) begin
            check_eq("latency", latency, exp_lat);
            check_eq("distance", distance, exp_dist);
        end
        exp_credit = w ? f.vc : '0;
        exp_rcv = w && f.kind == flit_pkg::TAIL;
        exp_lat = 16'(cyc) - f.payload[15:0];
        exp_dist = 4'((sink_sx > current_x ? sink_sx - current_x : current_x - sink_sx)
                 + (sink_sy > current_y ? sink_sy - current_y : current_y - sink_sy) + 1);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
            failed++;
        end
    endtask

    initial begin
        #2000000;
        $display("watchdog: simulation ran too long");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int e0, ts, size, hdrs, lo, hi;
        flit_pkg::flit_t f;
        void'($urandom(32'h7bf67c52));
        clk = 0;
        reset = 1;
        start = 0;
        ratio = 0;
        pck_size = 4;
        current_x = 1;
        current_y = 2;
        dest_x = 3;
        dest_y = 0;
        credit_in = '0;
        flit_in = '0;
        flit_in_wr = 0;
        hold_credits = 0;
        exp_credit = '0;
        exp_rcv = 0;

        e0 = errors;
        repeat (16) begin
            @(negedge clk);
            check_eq("flit_out_wr", flit_out_wr, 0);
            check_eq("sent_done", sent_done, 0);
            check_eq("credit_out", credit_out, 0);
            check_eq("pck_received", pck_received, 0);
            check_eq("pck_number", pck_number, 0);
        end
        @(posedge clk) reset <= 0;
        @(negedge clk);
        check_eq("flit_out_wr", flit_out_wr, 0);
        check_eq("sent_done", sent_done, 0);
        check_eq("credit_out", credit_out, 0);
        check_eq("pck_received", pck_received, 0);
        check_eq("pck_number", pck_number, 0);
        report_test("reset", e0);

        @(posedge clk) start <= 1;
        e0 = errors;
        for (int p = 0; p < 12; p++) begin
            size = $urandom_range(10, 2);
            pick_dest();
            pck_size <= 4'(size);
            inject_packet(ts);
            collect_packet(size, ts);
        end
        report_test("packet format", e0);

        e0 = errors;
        hold_credits = 1;
        for (int p = 0; p < 8; p++) begin
            size = $urandom_range(10, 6);
            pick_dest();
            pck_size <= 4'(size);
            inject_packet(ts);
            collect_packet(size, ts);
        end
        hold_credits = 0;
        drain_sender();
        report_test("back-pressure", e0);

        e0 = errors;
        size = 4;
        @(posedge clk);
        pck_size <= 4'(size);
        dest_x <= current_x;
        dest_y <= current_y;
        inject_packet(ts);
        repeat (200) begin
            @(negedge clk);
            check_eq("flit_out_wr", flit_out_wr, 0);
        end
        pick_dest(); // stored packet leaves once the destination is valid
        collect_packet(size, ts);
        report_test("invalid destination", e0);

        e0 = errors;
        drain_sender();
        hdrs = 0;
        @(posedge clk) ratio <= 50;
        repeat (2000) begin
            @(negedge clk);
            if (flit_out_wr && flit_out.kind == flit_pkg::HEADER) hdrs++;
        end
        @(posedge clk) ratio <= 0;
        drain_sender();
        lo = (2000 * 50 / (100 * size)) * 85 / 100;
        hi = (2000 * 50 / (100 * size)) * 115 / 100;
        checks++;
        assert (hdrs >= lo && hdrs <= hi) else begin
            $display("injection rate off: %0d headers in 2000 cycles, wanted %0d to %0d",
                     hdrs, lo, hi);
            errors++;
        end
        report_test("injection ratio", e0);

        e0 = errors;
        for (int p = 0; p < 10; p++) begin
            size = $urandom_range(6, 2);
            sink_sx = $urandom_range(`NOC_NX - 1);
            sink_sy = $urandom_range(`NOC_NY - 1);
            ts = $urandom_range(16'hffff);
            f.vc = flit_pkg::vc_mask_t'(1 << $urandom_range(`NOC_V - 1));
            for (int i = 0; i < size; i++) begin
                if ($urandom_range(3) == 0) sink_step(0, '0);
                if (i == 0) begin
                    f.kind = flit_pkg::HEADER;
                    f.payload = {16'h0, 4'(current_x), 4'(current_y), 4'(sink_sx), 4'(sink_sy)};
                end else if (i == size - 1) begin
                    f.kind = flit_pkg::TAIL;
                    f.payload = {16'h0, 16'(ts)};
                end else begin
                    f.kind = flit_pkg::BODY;
                    f.payload = $urandom;
                end
                sink_step(1, f);
            end
        end
        sink_step(0, '0);
        sink_step(0, '0);
        report_test("sink", e0);

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0 && failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
